// File: src/vecu_pkg.sv
`default_nettype none

package vecu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned NrVregs   = 8;
  localparam int unsigned NrLanes   = 4;
  localparam int unsigned ElemW     = 16;
  localparam int unsigned VregAddrW = 3;

  // Core side widths
  localparam int unsigned IdW   = 4;
  localparam int unsigned XRegW = 5;
  localparam int unsigned LaneW = 2;
  localparam int unsigned OpW   = 4;

  typedef logic [VregAddrW-1:0] vreg_addr_t;
  typedef logic [ElemW-1:0]     elem_t;
  typedef elem_t [NrLanes-1:0]  vreg_data_t;
  typedef logic [IdW-1:0]       x_id_t;
  typedef logic [XRegW-1:0]     x_reg_t;

  // Codes 6 to 15 are illegal
  typedef enum logic [OpW-1:0] {
    OP_VADD  = 4'h0,
    OP_VSUB  = 4'h1,
    OP_VAND  = 4'h2,
    OP_VXOR  = 4'h3,
    OP_VADDI = 4'h4,
    OP_VMVXS = 4'h5
  } vecu_op_e;

  //////////////////////////////////////////////////////////////////////
  // Instruction formats
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    vecu_op_e    opcode;
    vreg_addr_t  vd;
    vreg_addr_t  vs1;
    vreg_addr_t  vs2;
    logic [18:0] unused;
  } vecu_instr_rr_t;

  // VADDI and VMVXS, lane index sits in the low imm bits
  typedef struct packed {
    vecu_op_e   opcode;
    vreg_addr_t vd;
    vreg_addr_t vs2;
    x_reg_t     rd;
    elem_t      imm;
    logic       unused;
  } vecu_instr_ri_t;

  typedef union packed {
    vecu_instr_rr_t rr;
    vecu_instr_ri_t ri;
  } vecu_instr_u;

  //////////////////////////////////////////////////////////////////////
  // Core interface and stage payloads
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    vecu_instr_u instr;
    x_id_t       id;
  } x_issue_req_t;

  typedef struct packed {
    logic accept;
    logic writeback;
  } x_issue_resp_t;

  typedef struct packed {
    x_id_t  id;
    x_reg_t rd;
    elem_t  data;
  } x_result_t;

  typedef struct packed {
    vecu_op_e           op;
    vreg_addr_t         vd;
    vreg_addr_t         vs1;
    vreg_addr_t         vs2;
    x_reg_t             rd;
    x_id_t              id;
    elem_t              imm;
    logic [LaneW-1:0]   lane;
    logic               vd_we;
    logic               scalar;
  } vecu_uop_t;

  typedef struct packed {
    vreg_addr_t vd;
    logic       vd_we;
    logic       scalar;
    x_reg_t     rd;
    x_id_t      id;
    vreg_data_t result;
  } vecu_exe_t;

endpackage

`default_nettype wire

// File: src/vecu_issue.sv
`timescale 1ns/1ps
`default_nettype none

module vecu_issue (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  // Issue handshake with the core
  input  logic                    x_issue_valid_i,
  input  vecu_pkg::x_issue_req_t  x_issue_req_i,
  output logic                    x_issue_ready_o,
  output vecu_pkg::x_issue_resp_t x_issue_resp_o,
  input  logic                    stall_i,
  // Pending writers further down the pipe
  input  logic                    rd_valid_i,
  input  vecu_pkg::vecu_uop_t     rd_uop_i,
  input  logic                    ex_valid_i,
  input  vecu_pkg::vreg_addr_t    ex_vd_i,
  input  logic                    ex_we_i,
  input  logic                    wb_valid_i,
  input  vecu_pkg::vreg_addr_t    wb_vd_i,
  input  logic                    wb_we_i,
  // Read stage
  output logic                    uop_valid_o,
  output vecu_pkg::vecu_uop_t     uop_o,
  output vecu_pkg::vreg_addr_t    raddr_a_o,
  output vecu_pkg::vreg_addr_t    raddr_b_o
);

  vecu_pkg::vecu_instr_u instr;
  vecu_pkg::vecu_uop_t   dec;
  logic                  legal;
  logic                  use_vs1;
  logic                  use_vs2;
  logic                  hazard;
  logic                  fire;
  logic                  uop_valid_q;
  vecu_pkg::vecu_uop_t   uop_q;

  // True when a source of the decoded instruction reads vd
  function automatic logic src_hit(input vecu_pkg::vreg_addr_t vd,
                                   input vecu_pkg::vecu_uop_t  u,
                                   input logic                 a_used,
                                   input logic                 b_used);
    src_hit = (a_used && (u.vs1 == vd)) || (b_used && (u.vs2 == vd));
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  assign instr = x_issue_req_i.instr;

  always_comb begin
    dec     = '0;
    dec.op  = instr.rr.opcode;
    dec.id  = x_issue_req_i.id;
    legal   = 1'b1;
    use_vs1 = 1'b0;
    use_vs2 = 1'b1;
    case (instr.rr.opcode)
      vecu_pkg::OP_VADD, vecu_pkg::OP_VSUB, vecu_pkg::OP_VAND, vecu_pkg::OP_VXOR: begin
        dec.vd    = instr.rr.vd;
        dec.vs1   = instr.rr.vs1;
        dec.vs2   = instr.rr.vs2;
        dec.vd_we = 1'b1;
        use_vs1   = 1'b1;
      end
      vecu_pkg::OP_VADDI: begin
        dec.vd    = instr.ri.vd;
        dec.vs2   = instr.ri.vs2;
        dec.imm   = instr.ri.imm;
        dec.vd_we = 1'b1;
      end
      vecu_pkg::OP_VMVXS: begin
        dec.vs2    = instr.ri.vs2;
        dec.rd     = instr.ri.rd;
        dec.imm    = instr.ri.imm;
        dec.lane   = instr.ri.imm[vecu_pkg::LaneW-1:0];
        dec.scalar = 1'b1;
      end
      default: begin
        // Illegal code, no sources to wait for
        legal   = 1'b0;
        use_vs2 = 1'b0;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Scoreboard and handshake
  //////////////////////////////////////////////////////////////////////

  assign hazard = (rd_valid_i && rd_uop_i.vd_we && src_hit(rd_uop_i.vd, dec, use_vs1, use_vs2))
               || (ex_valid_i && ex_we_i && src_hit(ex_vd_i, dec, use_vs1, use_vs2))
               || (wb_valid_i && wb_we_i && src_hit(wb_vd_i, dec, use_vs1, use_vs2));

  assign x_issue_ready_o          = !stall_i && !hazard;
  assign fire                     = x_issue_valid_i && x_issue_ready_o;
  assign x_issue_resp_o.accept    = legal;
  assign x_issue_resp_o.writeback = legal && dec.scalar;

  // Register file is read on the acceptance edge
  assign raddr_a_o = dec.vs1;
  assign raddr_b_o = dec.vs2;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      uop_valid_q <= 1'b0;
    end else if (!stall_i) begin
      uop_valid_q <= fire && legal;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire && legal) begin
      uop_q <= dec;
    end
  end

  assign uop_valid_o = uop_valid_q;
  assign uop_o       = uop_q;

endmodule

`default_nettype wire

// File: src/vecu_vrf.sv
`timescale 1ns/1ps
`default_nettype none

module vecu_vrf (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  // Read ports
  input  vecu_pkg::vreg_addr_t raddr_a_i,
  input  vecu_pkg::vreg_addr_t raddr_b_i,
  input  logic                 re_i,
  output vecu_pkg::vreg_data_t rdata_a_o,
  output vecu_pkg::vreg_data_t rdata_b_o,
  // Write port
  input  vecu_pkg::vreg_addr_t waddr_i,
  input  vecu_pkg::vreg_data_t wdata_i,
  input  logic                 we_i
);

  vecu_pkg::vreg_data_t [vecu_pkg::NrVregs-1:0] regs_q;
  vecu_pkg::vreg_data_t                         rdata_a_q;
  vecu_pkg::vreg_data_t                         rdata_b_q;

  // Read with the write of the same cycle forwarded
  function automatic vecu_pkg::vreg_data_t fwd_read(input vecu_pkg::vreg_addr_t addr);
    if (we_i && (waddr_i == addr)) begin
      return wdata_i;
    end
    return regs_q[addr];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      regs_q <= '0;
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Read data holds while re_i is low
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_a_q <= fwd_read(raddr_a_i);
      rdata_b_q <= fwd_read(raddr_b_i);
    end
  end

  assign rdata_a_o = rdata_a_q;
  assign rdata_b_o = rdata_b_q;

endmodule

`default_nettype wire

// File: src/vecu_vfu.sv
`timescale 1ns/1ps
`default_nettype none

module vecu_vfu (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 stall_i,
  // Read stage
  input  logic                 uop_valid_i,
  input  vecu_pkg::vecu_uop_t  uop_i,
  input  vecu_pkg::vreg_data_t rdata_a_i,
  input  vecu_pkg::vreg_data_t rdata_b_i,
  // Execute stage
  output logic                 ex_valid_o,
  output vecu_pkg::vecu_exe_t  ex_o,
  // Scoreboard view
  output vecu_pkg::vreg_addr_t ex_vd_o,
  output logic                 ex_we_o
);

  vecu_pkg::vreg_data_t alu_res;
  vecu_pkg::vecu_exe_t  ex_d;
  logic                 ex_valid_q;
  vecu_pkg::vecu_exe_t  ex_q;

  //////////////////////////////////////////////////////////////////////
  // Lane ALU
  //////////////////////////////////////////////////////////////////////

  // All lanes wrap at 16 bits
  always_comb begin
    alu_res = '0;
    for (int unsigned l = 0; l < vecu_pkg::NrLanes; l++) begin
      case (uop_i.op)
        vecu_pkg::OP_VADD:  alu_res[l] = rdata_a_i[l] + rdata_b_i[l];
        vecu_pkg::OP_VSUB:  alu_res[l] = rdata_b_i[l] - rdata_a_i[l];
        vecu_pkg::OP_VAND:  alu_res[l] = rdata_a_i[l] & rdata_b_i[l];
        vecu_pkg::OP_VXOR:  alu_res[l] = rdata_a_i[l] ^ rdata_b_i[l];
        // Immediate broadcast to every lane
        vecu_pkg::OP_VADDI: alu_res[l] = rdata_b_i[l] + uop_i.imm;
        default:            alu_res[l] = '0;
      endcase
    end

    // Lane selection for the move to the core
    if (uop_i.op == vecu_pkg::OP_VMVXS) begin
      alu_res[0] = rdata_b_i[uop_i.lane];
    end
  end

  always_comb begin
    ex_d        = '0;
    ex_d.vd     = uop_i.vd;
    ex_d.vd_we  = uop_i.vd_we;
    ex_d.scalar = uop_i.scalar;
    ex_d.rd     = uop_i.rd;
    ex_d.id     = uop_i.id;
    ex_d.result = alu_res;
  end

  //////////////////////////////////////////////////////////////////////
  // Execute register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_valid_q <= 1'b0;
    end else if (!stall_i) begin
      ex_valid_q <= uop_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      ex_q <= ex_d;
    end
  end

  assign ex_valid_o = ex_valid_q;
  assign ex_o       = ex_q;
  assign ex_vd_o    = ex_q.vd;
  assign ex_we_o    = ex_q.vd_we;

endmodule

`default_nettype wire

// File: src/vecu_result.sv
`timescale 1ns/1ps
`default_nettype none

module vecu_result (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  // From execute
  input  logic                 ex_valid_i,
  input  vecu_pkg::vecu_exe_t  ex_i,
  // Register file write port
  output vecu_pkg::vreg_addr_t waddr_o,
  output vecu_pkg::vreg_data_t wdata_o,
  output logic                 we_o,
  // Scoreboard view
  output logic                 wb_valid_o,
  output vecu_pkg::vreg_addr_t wb_vd_o,
  output logic                 wb_we_o,
  output logic                 stall_o,
  // Result handshake with the core
  output logic                 x_result_valid_o,
  input  logic                 x_result_ready_i,
  output vecu_pkg::x_result_t  x_result_o
);

  logic                wb_valid_q;
  vecu_pkg::vecu_exe_t wb_q;

  //////////////////////////////////////////////////////////////////////
  // Writeback register
  //////////////////////////////////////////////////////////////////////

  // Frozen while a scalar result waits for the core
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_valid_q <= 1'b0;
    end else if (!stall_o) begin
      wb_valid_q <= ex_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_o) begin
      wb_q <= ex_i;
    end
  end

  // A writing item never stalls, so it writes exactly once
  assign waddr_o = wb_q.vd;
  assign wdata_o = wb_q.result;
  assign we_o    = wb_valid_q && wb_q.vd_we;

  assign wb_valid_o = wb_valid_q;
  assign wb_vd_o    = wb_q.vd;
  assign wb_we_o    = wb_q.vd_we;

  //////////////////////////////////////////////////////////////////////
  // Scalar result
  //////////////////////////////////////////////////////////////////////

  assign x_result_valid_o = wb_valid_q && wb_q.scalar;
  assign stall_o          = x_result_valid_o && !x_result_ready_i;

  always_comb begin
    x_result_o.id   = wb_q.id;
    x_result_o.rd   = wb_q.rd;
    x_result_o.data = wb_q.result[0];
  end

endmodule

`default_nettype wire

// File: src/vecu.sv
`timescale 1ns/1ps
`default_nettype none

module vecu (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  // Issue interface
  input  logic                    x_issue_valid_i,
  output logic                    x_issue_ready_o,
  input  vecu_pkg::x_issue_req_t  x_issue_req_i,
  output vecu_pkg::x_issue_resp_t x_issue_resp_o,
  // Result interface
  output logic                    x_result_valid_o,
  input  logic                    x_result_ready_i,
  output vecu_pkg::x_result_t     x_result_o
);

  logic                 stall;
  // Read stage
  logic                 rd_valid;
  vecu_pkg::vecu_uop_t  rd_uop;
  vecu_pkg::vreg_addr_t raddr_a;
  vecu_pkg::vreg_addr_t raddr_b;
  vecu_pkg::vreg_data_t rdata_a;
  vecu_pkg::vreg_data_t rdata_b;
  // Execute stage
  logic                 ex_valid;
  vecu_pkg::vecu_exe_t  ex;
  vecu_pkg::vreg_addr_t ex_vd;
  logic                 ex_we;
  // Writeback stage
  logic                 wb_valid;
  vecu_pkg::vreg_addr_t wb_vd;
  logic                 wb_we;
  vecu_pkg::vreg_addr_t vrf_waddr;
  vecu_pkg::vreg_data_t vrf_wdata;
  logic                 vrf_we;

  //////////////////////////////////////////////////////////////////////
  // Issue and register file
  //////////////////////////////////////////////////////////////////////

  vecu_issue i_issue (
    .clk_i          (clk_i          ),
    .arst_n_i       (arst_n_i       ),
    .x_issue_valid_i(x_issue_valid_i),
    .x_issue_req_i  (x_issue_req_i  ),
    .x_issue_ready_o(x_issue_ready_o),
    .x_issue_resp_o (x_issue_resp_o ),
    .stall_i        (stall          ),
    .rd_valid_i     (rd_valid       ),
    .rd_uop_i       (rd_uop         ),
    .ex_valid_i     (ex_valid       ),
    .ex_vd_i        (ex_vd          ),
    .ex_we_i        (ex_we          ),
    .wb_valid_i     (wb_valid       ),
    .wb_vd_i        (wb_vd          ),
    .wb_we_i        (wb_we          ),
    .uop_valid_o    (rd_valid       ),
    .uop_o          (rd_uop         ),
    .raddr_a_o      (raddr_a        ),
    .raddr_b_o      (raddr_b        )
  );

  // Reads advance together with the issue handshake
  vecu_vrf i_vrf (
    .clk_i    (clk_i          ),
    .arst_n_i (arst_n_i       ),
    .raddr_a_i(raddr_a        ),
    .raddr_b_i(raddr_b        ),
    .re_i     (x_issue_ready_o),
    .rdata_a_o(rdata_a        ),
    .rdata_b_o(rdata_b        ),
    .waddr_i  (vrf_waddr      ),
    .wdata_i  (vrf_wdata      ),
    .we_i     (vrf_we         )
  );

  //////////////////////////////////////////////////////////////////////
  // Execute and writeback
  //////////////////////////////////////////////////////////////////////

  vecu_vfu i_vfu (
    .clk_i      (clk_i   ),
    .arst_n_i   (arst_n_i),
    .stall_i    (stall   ),
    .uop_valid_i(rd_valid),
    .uop_i      (rd_uop  ),
    .rdata_a_i  (rdata_a ),
    .rdata_b_i  (rdata_b ),
    .ex_valid_o (ex_valid),
    .ex_o       (ex      ),
    .ex_vd_o    (ex_vd   ),
    .ex_we_o    (ex_we   )
  );

  vecu_result i_result (
    .clk_i           (clk_i           ),
    .arst_n_i        (arst_n_i        ),
    .ex_valid_i      (ex_valid        ),
    .ex_i            (ex              ),
    .waddr_o         (vrf_waddr       ),
    .wdata_o         (vrf_wdata       ),
    .we_o            (vrf_we          ),
    .wb_valid_o      (wb_valid        ),
    .wb_vd_o         (wb_vd           ),
    .wb_we_o         (wb_we           ),
    .stall_o         (stall           ),
    .x_result_valid_o(x_result_valid_o),
    .x_result_ready_i(x_result_ready_i),
    .x_result_o      (x_result_o      )
  );

endmodule

`default_nettype wire

// File: verification/vecu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vecu_tb;

  typedef struct packed {
    logic [2:0]              test;
    vecu_pkg::x_issue_req_t  req;
    vecu_pkg::x_issue_resp_t resp;
    logic                    has_res;
    vecu_pkg::x_result_t     res;
  } entry_t;

  logic                    clk_i;
  logic                    arst_n_i;
  logic                    x_issue_valid_i;
  logic                    x_issue_ready_o;
  vecu_pkg::x_issue_req_t  x_issue_req_i;
  vecu_pkg::x_issue_resp_t x_issue_resp_o;
  logic                    x_result_valid_o;
  logic                    x_result_ready_i;
  vecu_pkg::x_result_t     x_result_o;

  entry_t               tbl[$];
  entry_t               idle_e = '0;
  vecu_pkg::x_result_t  exp_q[$];
  vecu_pkg::vreg_data_t model_rf [vecu_pkg::NrVregs];
  vecu_pkg::x_id_t      next_id = '0;
  logic [15:0]          lfsr_q = 16'd7;
  logic                 table_ready = 1'b0;
  int                   pos = 0;
  int                   err_cnt = 0;
  int                   n_checks = 0;
  int                   n_pass = 0;
  int                   n_fail = 0;
  string                test_names [6] = '{"reset", "vaddi and vmvxs", "alu ops",
                                           "raw chains", "back-pressure", "illegal opcode"};

  vecu u_dut (
    .clk_i           (clk_i           ),
    .arst_n_i        (arst_n_i        ),
    .x_issue_valid_i (x_issue_valid_i ),
    .x_issue_ready_o (x_issue_ready_o ),
    .x_issue_req_i   (x_issue_req_i   ),
    .x_issue_resp_o  (x_issue_resp_o  ),
    .x_result_valid_o(x_result_valid_o),
    .x_result_ready_i(x_result_ready_i),
    .x_result_o      (x_result_o      )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////////////

  // Galois form, taps for a maximal 16-bit sequence
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[6:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Per-lane result, wrapped to 16 bits by modulo
  function automatic vecu_pkg::vreg_data_t model_alu(input vecu_pkg::vecu_op_e op,
      input vecu_pkg::vreg_data_t a, input vecu_pkg::vreg_data_t b, input vecu_pkg::elem_t imm);
    vecu_pkg::vreg_data_t r;
    int s;
    for (int unsigned l = 0; l < vecu_pkg::NrLanes; l++) begin
      case (op)
        vecu_pkg::OP_VADD: s = int'(a[l]) + int'(b[l]);
        vecu_pkg::OP_VSUB: s = int'(b[l]) - int'(a[l]) + 65536;
        vecu_pkg::OP_VAND: s = int'(a[l] & b[l]);
        vecu_pkg::OP_VXOR: s = int'(a[l] ^ b[l]);
        default:           s = int'(b[l]) + int'(imm);
      endcase
      r[l] = vecu_pkg::elem_t'(s % 65536);
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Table construction
  ////////////////////////////////////////////////////////////////////

  function automatic void add_rr(input logic [2:0] t, input vecu_pkg::vecu_op_e op,
      input vecu_pkg::vreg_addr_t vd, input vecu_pkg::vreg_addr_t vs1,
      input vecu_pkg::vreg_addr_t vs2);
    entry_t e;
    vecu_pkg::vecu_instr_rr_t w;
    w = '0;
    w.opcode = op;
    w.vd = vd;
    w.vs1 = vs1;
    w.vs2 = vs2;
    e = '0;
    e.test = t;
    e.req.instr.rr = w;
    e.req.id = next_id;
    e.resp.accept = 1'b1;
    model_rf[vd] = model_alu(op, model_rf[vs1], model_rf[vs2], '0);
    next_id = next_id + 4'd1;
    tbl.push_back(e);
  endfunction

  function automatic void add_ri(input logic [2:0] t, input vecu_pkg::vecu_op_e op,
      input vecu_pkg::vreg_addr_t vd, input vecu_pkg::vreg_addr_t vs2,
      input vecu_pkg::x_reg_t rd, input vecu_pkg::elem_t imm);
    entry_t e;
    vecu_pkg::vecu_instr_ri_t w;
    w = '0;
    w.opcode = op;
    w.vd = vd;
    w.vs2 = vs2;
    w.rd = rd;
    w.imm = imm;
    e = '0;
    e.test = t;
    e.req.instr.ri = w;
    e.req.id = next_id;
    e.resp.accept = 1'b1;
    if (op == vecu_pkg::OP_VMVXS) begin
      e.resp.writeback = 1'b1;
      e.has_res = 1'b1;
      e.res.id = next_id;
      e.res.rd = rd;
      e.res.data = model_rf[vs2][imm[1:0]];
    end else begin
      model_rf[vd] = model_alu(op, '0, model_rf[vs2], imm);
    end
    next_id = next_id + 4'd1;
    tbl.push_back(e);
  endfunction

  function automatic void add_mv(input logic [2:0] t, input vecu_pkg::vreg_addr_t vs2,
      input logic [1:0] lane, input vecu_pkg::x_reg_t rd);
    add_ri(t, vecu_pkg::OP_VMVXS, 3'd0, vs2, rd, vecu_pkg::elem_t'(lane));
  endfunction

  // Accepted with accept low, register file untouched
  function automatic void add_illegal(input logic [2:0] t, input logic [3:0] code,
      input vecu_pkg::vreg_addr_t vd);
    entry_t e;
    e = '0;
    e.test = t;
    e.req.instr.rr.opcode = vecu_pkg::vecu_op_e'(code);
    e.req.instr.rr.vd = vd;
    e.req.instr.rr.vs1 = vd;
    e.req.instr.rr.vs2 = vd;
    e.req.id = next_id;
    next_id = next_id + 4'd1;
    tbl.push_back(e);
  endfunction

  function automatic void build_table();
    vecu_pkg::vecu_op_e   op;
    vecu_pkg::vreg_addr_t vd;
    vecu_pkg::vreg_addr_t vs1;
    vecu_pkg::vreg_addr_t vs2;
    for (int r = 0; r < vecu_pkg::NrVregs; r++) begin
      model_rf[r] = '0;
    end
    add_ri(3'd1, vecu_pkg::OP_VADDI, 3'd1, 3'd0, 5'd0, 16'h0011);
    add_ri(3'd2, vecu_pkg::OP_VADDI, 3'd2, 3'd0, 5'd0, 16'h1234);
    add_ri(3'd2, vecu_pkg::OP_VADDI, 3'd3, 3'd0, 5'd0, 16'hFFFF);
    add_ri(3'd2, vecu_pkg::OP_VADDI, 3'd4, 3'd0, 5'd0, 16'h8000);
    for (int r = 1; r <= 4; r++) begin
      for (int l = 0; l < 4; l++) begin
        add_mv(3'd2, vecu_pkg::vreg_addr_t'(r), 2'(l), vecu_pkg::x_reg_t'(r * 4 + l));
      end
    end
    // Wraparound in both directions
    add_ri(3'd3, vecu_pkg::OP_VADDI, 3'd5, 3'd3, 5'd0, 16'h0002);
    add_rr(3'd3, vecu_pkg::OP_VADD, 3'd6, 3'd3, 3'd4);
    add_rr(3'd3, vecu_pkg::OP_VSUB, 3'd7, 3'd2, 3'd1);
    for (int r = 5; r <= 7; r++) begin
      add_mv(3'd3, vecu_pkg::vreg_addr_t'(r), 2'(r), vecu_pkg::x_reg_t'(r));
    end
    add_rr(3'd3, vecu_pkg::OP_VAND, 3'd5, 3'd2, 3'd7);
    add_rr(3'd3, vecu_pkg::OP_VXOR, 3'd6, 3'd2, 3'd4);
    add_mv(3'd3, 3'd5, 2'd0, 5'd21);
    add_mv(3'd3, 3'd6, 2'd3, 5'd22);
    add_ri(3'd4, vecu_pkg::OP_VADDI, 3'd1, 3'd1, 5'd0, 16'h0001);
    add_rr(3'd4, vecu_pkg::OP_VADD, 3'd1, 3'd1, 3'd1);
    add_rr(3'd4, vecu_pkg::OP_VSUB, 3'd2, 3'd1, 3'd2);
    add_rr(3'd4, vecu_pkg::OP_VXOR, 3'd3, 3'd2, 3'd1);
    add_mv(3'd4, 3'd3, 2'd2, 5'd9);
    add_rr(3'd4, vecu_pkg::OP_VAND, 3'd4, 3'd3, 3'd1);
    add_mv(3'd4, 3'd4, 2'd1, 5'd10);
    for (int k = 0; k < 10; k++) begin
      op  = vecu_pkg::vecu_op_e'(4'(rand_bits(2)));
      vd  = vecu_pkg::vreg_addr_t'(rand_bits(3));
      vs1 = vecu_pkg::vreg_addr_t'(rand_bits(3));
      vs2 = vecu_pkg::vreg_addr_t'(rand_bits(3));
      add_rr(3'd5, op, vd, vs1, vs2);
      add_mv(3'd5, vd, 2'(rand_bits(2)), vecu_pkg::x_reg_t'(rand_bits(5)));
    end
    add_illegal(3'd6, 4'hA, 3'd2);
    add_illegal(3'd6, 4'hF, 3'd5);
    add_mv(3'd6, 3'd2, 2'd1, 5'd30);
    add_mv(3'd6, 3'd5, 2'd3, 5'd31);
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Checks and cycle stepping
  ////////////////////////////////////////////////////////////////////

  task automatic check_flag(input logic got, input logic exp, input string what);
    n_checks++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0d ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input vecu_pkg::x_issue_resp_t got,
                            input vecu_pkg::x_issue_resp_t exp, input int idx);
    n_checks++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0d ns: entry %0d response accept/writeback got %b/%b expected %b/%b",
               $time, idx, got.accept, got.writeback, exp.accept, exp.writeback);
    end
  endtask

  task automatic check_result(input vecu_pkg::x_result_t got, input vecu_pkg::x_result_t exp);
    n_checks++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0d ns: result id/rd/data got %0d/%0d/%h expected %0d/%0d/%h",
               $time, got.id, got.rd, got.data, exp.id, exp.rd, exp.data);
    end
  endtask

  // Drive on the falling edge, sample once the inputs have settled
  task automatic step_cycle(input logic offer, input entry_t e, output logic took);
    @(negedge clk_i);
    lfsr_q = lfsr_next(lfsr_q);
    x_result_ready_i = lfsr_q[0];
    x_issue_valid_i = offer;
    x_issue_req_i = e.req;
    #1;
    if (x_result_valid_o && x_result_ready_i) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("error at %0d ns: result id %0d arrived with none expected", $time, x_result_o.id);
      end else begin
        check_result(x_result_o, exp_q.pop_front());
      end
    end
    took = offer && x_issue_ready_o;
    if (took) begin
      check_resp(x_issue_resp_o, e.resp, pos);
      if (e.has_res) begin
        exp_q.push_back(e.res);
      end
    end
  endtask

  task automatic run_test(input logic [2:0] t);
    int   e0;
    logic took;
    e0 = err_cnt;
    while (pos < tbl.size() && tbl[pos].test == t) begin
      step_cycle(1'b1, tbl[pos], took);
      if (took) begin
        pos++;
      end
    end
    while (exp_q.size() != 0) begin
      step_cycle(1'b0, idle_e, took);
    end
    // A few idle cycles catch stray results
    repeat (4) step_cycle(1'b0, idle_e, took);
    if (err_cnt == e0) begin
      n_pass++;
      $display("test %0d %s: ok", t, test_names[t - 1]);
    end else begin
      n_fail++;
      $display("test %0d %s: FAILED with %0d errors", t, test_names[t - 1], err_cnt - e0);
    end
  endtask

  initial begin
    arst_n_i = 1'b0;
    x_issue_valid_i = 1'b0;
    x_issue_req_i = '0;
    x_result_ready_i = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (3) @(negedge clk_i);
    arst_n_i = 1'b1;
    #1;
    check_flag(x_result_valid_o, 1'b0, "result valid after reset");
    check_flag(x_issue_ready_o, 1'b1, "issue ready after reset");
    for (int t = 1; t <= 6; t++) begin
      run_test(3'(t));
    end
    $display("tests passed %0d failed %0d, checks %0d, errors %0d",
             n_pass, n_fail, n_checks, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (table_ready);
    repeat (tbl.size() * 40) @(posedge clk_i);
    $display("timeout: the run did not finish within %0d cycles", tbl.size() * 40);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vecu.f
src/vecu_pkg.sv
src/vecu_issue.sv
src/vecu_vrf.sv
src/vecu_vfu.sv
src/vecu_result.sv
src/vecu.sv
verification/vecu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f vecu.f --top-module vecu_tb -o vecu_sim \
  && ./obj_dir/vecu_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -qx "sim passed" sim.log && exit 0 || exit 1
